/* baseball.f */
+incdir+include
verilog/game_pkg.sv
verilog/display_pkg.sv
verilog/key_entry.sv
verilog/secret_gen.sv
verilog/round_judge.sv
verilog/seg_scan.sv
verilog/baseball_top.sv
bench/score_checker.sv
bench/tb_baseball.sv

/* Bender.yml */
package:
  name: baseball

export_include_dirs:
  - include

sources:
  - files:
      - verilog/game_pkg.sv
      - verilog/display_pkg.sv
      - verilog/key_entry.sv
      - verilog/secret_gen.sv
      - verilog/round_judge.sv
      - verilog/seg_scan.sv
      - verilog/baseball_top.sv
  - target: simulation
    files:
      - bench/score_checker.sv
      - bench/tb_baseball.sv

/* bench/baseball_stim.txt */
// fields in hex: op keys k0 k1 k2 k3 k4 strikes balls flag
// op 1 seed, 2 scored guess, 3 guess with no score; flag 0 playing, 1 won, 2 lost
// default secret 4 2 1
2 3 4 2 1 0 0 3 0 1
// seed 1 2 3 4, lfsr shifts to 2469, secret 3 5 7
1 4 1 2 3 4 0 0 0 0
2 3 1 2 4 0 0 0 0 0
// second 3 and the 0 are rejected
2 5 3 3 0 5 9 2 0 0
2 3 7 3 5 0 0 0 3 0
2 4 5 0 7 1 0 0 2 0
2 3 3 7 5 0 0 1 2 0
2 3 9 8 6 0 0 0 0 0
2 5 2 2 2 5 7 2 0 0
2 3 8 5 3 0 0 1 1 0
2 3 6 3 1 0 0 0 1 0
// tenth miss loses
2 3 3 5 8 0 0 2 0 2
3 3 3 5 7 0 0 0 0 2

/* bench/tb_baseball.sv */
// run from the project root so bench/baseball_stim.txt is found; at most 32 stimulus records
`timescale 1ns/1ps
`default_nettype none
`include "baseball_config.svh"

module tb_baseball;
  import game_pkg::*;
  import display_pkg::*;

  localparam int FIELDS   = 10;
  localparam int MAX_RECS = 32;

  logic       clk;
  logic       sharp_rst;
  logic [9:0] numpad;
  logic       star;
  logic       seed_mode;
  seg_t       seg;
  seg_pos_t   seg_pos;
  logic [3:0] seed_led;
  logic       win_led;
  logic       lose_led;
  score_t     score;
  logic       score_valid;

  logic [7:0] stim [0:MAX_RECS*FIELDS-1];
  logic       expect_score;
  score_t     exp_score;
  logic [1:0] exp_flag;
  logic       check_leds;
  int         score_errs;
  int         led_errs;
  int         disp_errs;
  int         scores_seen;
  int         disp_checks;
  int         seq_errs;
  int         n_recs;
  int         n_scored;
  int         cycles = 0;
  int         cycle_limit = 0;

  baseball_top dut0 (
    .clk           (clk),
    .sharp_rst     (sharp_rst),
    .i_numpad      (numpad),
    .i_star        (star),
    .i_seed_mode   (seed_mode),
    .o_seg         (seg),
    .o_seg_pos     (seg_pos),
    .o_seed_led    (seed_led),
    .o_win_led     (win_led),
    .o_lose_led    (lose_led),
    .o_score       (score),
    .o_score_valid (score_valid)
  );

  score_checker u_checker (
    .clk            (clk),
    .sharp_rst      (sharp_rst),
    .i_star         (star),
    .i_seed_mode    (seed_mode),
    .i_score_valid  (score_valid),
    .i_score        (score),
    .i_win_led      (win_led),
    .i_lose_led     (lose_led),
    .i_seed_led     (seed_led),
    .i_seg          (seg),
    .i_seg_pos      (seg_pos),
    .i_expect_score (expect_score),
    .i_exp_score    (exp_score),
    .i_exp_flag     (exp_flag),
    .i_check_leds   (check_leds),
    .o_score_errs   (score_errs),
    .o_led_errs     (led_errs),
    .o_disp_errs    (disp_errs),
    .o_scores_seen  (scores_seen),
    .o_disp_checks  (disp_checks)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // digit strobe, random gap, then the star that stores it
  task automatic press_key(input logic [3:0] d);
    int gap;
    gap = $urandom_range(2);
    @(negedge clk);
    numpad = 10'b1 << d;
    @(negedge clk);
    numpad = '0;
    repeat (gap) @(negedge clk);
    star = 1'b1;
    @(negedge clk);
    star = 1'b0;
  endtask

  task automatic press_submit;
    @(negedge clk);
    star = 1'b1;
    @(negedge clk);
    star = 1'b0;
  endtask

  task automatic wait_score(input int limit, output bit got);
    got = 1'b0;
    for (int i = 0; i < limit && !got; i++) begin
      @(posedge clk);
      if (score_valid) begin
        got = 1'b1;
      end
    end
  endtask

  function automatic bit record_ok(input int r);
    return stim[r*FIELDS] >= 8'd1 && stim[r*FIELDS] <= 8'd3;
  endfunction

  task automatic run_record(input int r);
    int         base;
    int         nk;
    int         limit;
    logic [7:0] op;
    bit         got;
    base     = r * FIELDS;
    op       = stim[base];
    nk       = stim[base+1];
    exp_flag = stim[base+9][1:0];
    if (op == 8'd1) begin
      @(negedge clk);
      seed_mode = 1'b1;
      for (int k = 0; k < nk; k++) begin
        press_key(stim[base+2+k][3:0]);
      end
      idle(6); // seed strobe, lfsr shift, secret strobe
      seed_mode = 1'b0;
      idle(2);
    end else begin
      for (int k = 0; k < nk; k++) begin
        press_key(stim[base+2+k][3:0]);
      end
      exp_score.strikes = stim[base+7][1:0];
      exp_score.balls   = stim[base+8][1:0];
      expect_score      = (op == 8'd2);
      limit             = (op == 8'd2) ? 8 : `BB_HOLD_CYCLES + 8;
      press_submit();
      wait_score(limit, got);
      if (op == 8'd2 && !got) begin
        $display("no score came out for stimulus record %0d", r);
        seq_errs++;
      end
      @(negedge clk);
      expect_score = 1'b0;
      if (op == 8'd2) begin
        idle(`BB_HOLD_CYCLES + 3); // back in ENTRY
      end
    end
    @(negedge clk);
    check_leds = 1'b1;
    @(negedge clk);
    check_leds = 1'b0;
  endtask

  initial begin
    void'($urandom(96870));
    sharp_rst    = 1'b0;
    numpad       = '0;
    star         = 1'b0;
    seed_mode    = 1'b0;
    expect_score = 1'b0;
    exp_score    = '0;
    exp_flag     = 2'd0;
    check_leds   = 1'b0;
    seq_errs     = 0;
    n_scored     = 0;
    for (int i = 0; i < MAX_RECS * FIELDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("bench/baseball_stim.txt", stim);
    n_recs = 0;
    while (n_recs < MAX_RECS && record_ok(n_recs)) begin
      if (stim[n_recs*FIELDS] == 8'd2) begin
        n_scored++;
      end
      n_recs++;
    end
    cycle_limit = n_recs * (`BB_HOLD_CYCLES + 40) + 200;
    if (n_recs == 0) begin
      $display("no stimulus records were read from bench/baseball_stim.txt");
      seq_errs++;
    end
    repeat (5) @(negedge clk);
    sharp_rst = 1'b1;
    idle(3);
    for (int r = 0; r < n_recs; r++) begin
      run_record(r);
    end
    idle(2);
    if (scores_seen != n_scored) begin
      $display("the DUT gave %0d scores where %0d were due", scores_seen, n_scored);
      seq_errs++;
    end
    if (disp_checks == 0) begin
      $display("the score display was never seen during a hold");
      seq_errs++;
    end
    $display("errors: score %0d, led %0d, display %0d, sequence %0d",
             score_errs, led_errs, disp_errs, seq_errs);
    if (score_errs + led_errs + disp_errs + seq_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/score_checker.sv */
// expected values come from the testbench; display checks assume HOLD lasts BB_HOLD_CYCLES
`timescale 1ns/1ps
`default_nettype none
`include "baseball_config.svh"

module score_checker (
  input  wire                   clk,
  input  wire                   sharp_rst,
  input  wire                   i_star,
  input  wire                   i_seed_mode,
  input  wire                   i_score_valid,
  input  game_pkg::score_t      i_score,
  input  wire                   i_win_led,
  input  wire                   i_lose_led,
  input  wire [3:0]             i_seed_led,
  input  display_pkg::seg_t     i_seg,
  input  display_pkg::seg_pos_t i_seg_pos,
  input  wire                   i_expect_score,
  input  game_pkg::score_t      i_exp_score,
  input  wire [1:0]             i_exp_flag,
  input  wire                   i_check_leds,
  output int                    o_score_errs,
  output int                    o_led_errs,
  output int                    o_disp_errs,
  output int                    o_scores_seen,
  output int                    o_disp_checks
);
  import game_pkg::*;
  import display_pkg::*;

  int     since_star;
  int     seed_stars;
  int     hold_age;
  logic   hold_on;
  score_t held;

  // gfedcba patterns for counts 0 to 3
  function automatic seg_t count_glyph(input logic [1:0] n);
    seg_t g;
    case (n)
      2'd0: g = 7'h3f;
      2'd1: g = 7'h06;
      2'd2: g = 7'h5b;
      default: g = 7'h4f;
    endcase
    return g;
  endfunction

  task automatic report_value(input string name, input int got, input int want);
    $display("ERROR at %0d ns: %s = %0h, expected %0h", $time, name, got, want);
  endtask

  always @(posedge clk) begin : watch
    int se;
    int le;
    int de;
    int dc;
    se = 0;
    le = 0;
    de = 0;
    dc = 0;
    if (!sharp_rst) begin
      since_star    <= 100;
      seed_stars    <= 0;
      hold_age      <= 0;
      hold_on       <= 1'b0;
      held          <= '0;
      o_score_errs  <= 0;
      o_led_errs    <= 0;
      o_disp_errs   <= 0;
      o_scores_seen <= 0;
      o_disp_checks <= 0;
    end else begin
      if (i_seed_led !== 4'((1 << seed_stars) - 1)) begin // one more bit per seed star
        report_value("o_seed_led", i_seed_led, (1 << seed_stars) - 1);
        le++;
      end
      if (i_star && i_seed_mode) begin
        seed_stars <= (seed_stars == 4) ? 1 : seed_stars + 1;
      end
      since_star <= i_star ? 0 : since_star + 1;
      if (i_score_valid) begin
        o_scores_seen <= o_scores_seen + 1;
        if (!i_expect_score) begin
          $display("ERROR at %0d ns: o_score_valid rose while no score was due", $time);
          se++;
        end else begin
          if (i_score.strikes !== i_exp_score.strikes) begin
            report_value("o_score.strikes", i_score.strikes, i_exp_score.strikes);
            se++;
          end
          if (i_score.balls !== i_exp_score.balls) begin
            report_value("o_score.balls", i_score.balls, i_exp_score.balls);
            se++;
          end
          if (since_star + 1 != 2) begin
            report_value("o_score_valid latency", since_star + 1, 2);
            se++;
          end
        end
      end
      if ((i_score_valid && i_expect_score) || i_check_leds) begin
        if (i_win_led !== (i_exp_flag == 2'd1)) begin
          report_value("o_win_led", i_win_led, i_exp_flag == 2'd1);
          le++;
        end
        if (i_lose_led !== (i_exp_flag == 2'd2)) begin
          report_value("o_lose_led", i_lose_led, i_exp_flag == 2'd2);
          le++;
        end
      end
      if (i_score_valid && i_expect_score && i_exp_flag == 2'd0) begin
        hold_on  <= 1'b1;
        hold_age <= 1;
        held     <= i_exp_score;
      end else if (hold_on) begin
        if (i_seg_pos == 8'hf7) begin // strike digit
          dc++;
          if (i_seg !== count_glyph(held.strikes)) begin
            report_value("o_seg at position 3", i_seg, count_glyph(held.strikes));
            de++;
          end
        end else if (i_seg_pos == 8'hfb) begin
          dc++;
          if (i_seg !== GLYPH_S) begin
            report_value("o_seg at position 2", i_seg, GLYPH_S);
            de++;
          end
        end
        hold_age <= hold_age + 1;
        if (hold_age == `BB_HOLD_CYCLES - 1) begin
          hold_on <= 1'b0;
        end
      end
      o_score_errs  <= o_score_errs + se;
      o_led_errs    <= o_led_errs + le;
      o_disp_errs   <= o_disp_errs + de;
      o_disp_checks <= o_disp_checks + dc;
    end
  end

endmodule

`default_nettype wire

/* verilog/baseball_top.sv */
// keypad strobes must be one cycle wide; LEDs and o_score are active high
`timescale 1ns/1ps
`default_nettype none

module baseball_top (
  input  wire                   clk,
  input  wire                   sharp_rst,
  input  wire [9:0]             i_numpad,
  input  wire                   i_star,
  input  wire                   i_seed_mode,
  output display_pkg::seg_t     o_seg,
  output display_pkg::seg_pos_t o_seg_pos,
  output logic [3:0]            o_seed_led,
  output logic                  o_win_led,
  output logic                  o_lose_led,
  output game_pkg::score_t      o_score,
  output logic                  o_score_valid
);
  import game_pkg::*;

  guess_t      guess;
  logic        submit;
  seed_t       seed;
  logic        seed_stb;
  logic [3:0]  seed_fill;
  secret_t     secret;
  logic        secret_stb;
  game_state_t state;
  logic        key_en;
  logic        clear;

  assign o_win_led  = (state == WON);
  assign o_lose_led = (state == LOST);
  assign o_seed_led = seed_fill;

  key_entry u_key_entry (
    .clk         (clk),
    .sharp_rst   (sharp_rst),
    .i_numpad    (i_numpad),
    .i_star      (i_star),
    .i_seed_mode (i_seed_mode),
    .i_key_en    (key_en),
    .i_clear     (clear),
    .o_guess     (guess),
    .o_submit    (submit),
    .o_seed      (seed),
    .o_seed_stb  (seed_stb),
    .o_seed_fill (seed_fill)
  );

  secret_gen u_secret_gen (
    .clk          (clk),
    .sharp_rst    (sharp_rst),
    .i_seed       (seed),
    .i_seed_stb   (seed_stb),
    .o_secret     (secret),
    .o_secret_stb (secret_stb)
  );

  round_judge u_round_judge (
    .clk           (clk),
    .sharp_rst     (sharp_rst),
    .i_guess       (guess),
    .i_submit      (submit),
    .i_secret      (secret),
    .i_secret_stb  (secret_stb),
    .o_score       (o_score),
    .o_score_valid (o_score_valid),
    .o_state       (state),
    .o_key_en      (key_en),
    .o_clear       (clear)
  );

  seg_scan u_seg_scan (
    .clk       (clk),
    .sharp_rst (sharp_rst),
    .i_guess   (guess),
    .i_score   (o_score),
    .i_state   (state),
    .o_seg     (o_seg),
    .o_seg_pos (o_seg_pos)
  );

endmodule

`default_nettype wire

/* verilog/seg_scan.sv */
// one position lit at a time, BB_SCAN_DIV cycles each; score digits show only during HOLD
`timescale 1ns/1ps
`default_nettype none
`include "baseball_config.svh"

module seg_scan (
  input  wire                   clk,
  input  wire                   sharp_rst,
  input  game_pkg::guess_t      i_guess,
  input  game_pkg::score_t      i_score,
  input  game_pkg::game_state_t i_state,
  output display_pkg::seg_t     o_seg,
  output display_pkg::seg_pos_t o_seg_pos
);
  import game_pkg::*;
  import display_pkg::*;

  localparam int DIV_W = $clog2(`BB_SCAN_DIV + 1);

  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       pos;
  seg_t             glyph;
  logic             show_score;

  assign show_score = (i_state == HOLD);

  always_comb begin
    glyph = BLANK;
    case (pos)
      3'd7: if (i_guess.fill > 2'd0) glyph = digit_glyph(i_guess.d[0]);
      3'd6: if (i_guess.fill > 2'd1) glyph = digit_glyph(i_guess.d[1]);
      3'd5: if (i_guess.fill > 2'd2) glyph = digit_glyph(i_guess.d[2]);
      3'd3: if (show_score) glyph = digit_glyph({2'b00, i_score.strikes});
      3'd2: if (show_score) glyph = GLYPH_S;
      3'd1: if (show_score) glyph = digit_glyph({2'b00, i_score.balls});
      3'd0: if (show_score) glyph = GLYPH_B;
      default: glyph = BLANK; // position 4 unused
    endcase
  end

  always_ff @(posedge clk) begin
    if (!sharp_rst) begin
      div_cnt   <= '0;
      pos       <= 3'd7;
      o_seg     <= BLANK;
      o_seg_pos <= POS_NONE;
    end else begin
      if (div_cnt == DIV_W'(`BB_SCAN_DIV - 1)) begin
        div_cnt <= '0;
        pos     <= pos - 3'd1; // left to right
      end else begin
        div_cnt <= div_cnt + DIV_W'(1);
      end
      o_seg     <= glyph;
      o_seg_pos <= ~(seg_pos_t'(1) << pos);
    end
  end

endmodule

`default_nettype wire

/* verilog/round_judge.sv */
// submits outside ENTRY are dropped; hold counter is 16 bits wide
`timescale 1ns/1ps
`default_nettype none
`include "baseball_config.svh"

module round_judge (
  input  wire                   clk,
  input  wire                   sharp_rst,
  input  game_pkg::guess_t      i_guess,
  input  wire                   i_submit,
  input  game_pkg::secret_t     i_secret,
  input  wire                   i_secret_stb,
  output game_pkg::score_t      o_score,
  output logic                  o_score_valid,
  output game_pkg::game_state_t o_state,
  output logic                  o_key_en,
  output logic                  o_clear
);
  import game_pkg::*;

  localparam int HOLD_W = 16;

  game_state_t       state;
  try_cnt_t          tries;
  logic [HOLD_W-1:0] hold_cnt;
  logic              hold_done;
  score_t            score_now;

  always_comb begin
    score_now = '0;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        if (i_guess.d[i] == i_secret[j]) begin
          if (i == j) begin
            score_now.strikes = score_now.strikes + 2'd1;
          end else begin
            score_now.balls = score_now.balls + 2'd1;
          end
        end
      end
    end
  end

  assign hold_done = (hold_cnt == HOLD_W'(`BB_HOLD_CYCLES - 1));
  assign o_clear   = i_secret_stb | ((state == HOLD) && hold_done); // same edge as ENTRY
  assign o_key_en  = (state == ENTRY);
  assign o_state   = state;

  always_ff @(posedge clk) begin
    if (!sharp_rst) begin
      state         <= ENTRY;
      tries         <= '0;
      hold_cnt      <= '0;
      o_score       <= '0;
      o_score_valid <= 1'b0;
    end else begin
      o_score_valid <= 1'b0;
      if (i_secret_stb) begin
        state    <= ENTRY; // new game
        tries    <= '0;
        hold_cnt <= '0;
      end else begin
        case (state)
          ENTRY: begin
            if (i_submit) begin
              o_score       <= score_now;
              o_score_valid <= 1'b1;
              tries         <= tries + try_cnt_t'(1);
              hold_cnt      <= '0;
              if (score_now.strikes == 2'd3) begin
                state <= WON;
              end else if (tries == try_cnt_t'(`BB_MAX_TRIES - 1)) begin
                state <= LOST;
              end else begin
                state <= HOLD;
              end
            end
          end
          HOLD: begin
            hold_cnt <= hold_cnt + HOLD_W'(1);
            if (hold_done) begin
              state <= ENTRY;
            end
          end
          default: state <= state; // WON and LOST wait for reset or seed
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/secret_gen.sv */
// secret is 4, 2, 1 after reset; a new one appears two cycles after each seed strobe
`timescale 1ns/1ps
`default_nettype none
`include "baseball_config.svh"

module secret_gen (
  input  wire                 clk,
  input  wire                 sharp_rst,
  input  game_pkg::seed_t     i_seed,
  input  wire                 i_seed_stb,
  output game_pkg::secret_t   o_secret,
  output logic                o_secret_stb
);
  import game_pkg::*;

  localparam secret_t DEFAULT_SECRET = {4'd1, 4'd2, 4'd4}; // slot 0 holds 4

  seed_t lfsr;
  seed_t lfsr_next;
  logic  load_q;

  assign lfsr_next = {lfsr[14:0], ^(lfsr & `BB_LFSR_TAPS)};

  // maps 0..15 onto 1..9, and 9 wraps to 1
  function automatic digit_t wrap9(input digit_t v);
    digit_t r;
    r = (v % 4'd9) + 4'd1;
    return r;
  endfunction

  function automatic secret_t derive(input seed_t s);
    secret_t d;
    d[0] = wrap9(s[15:12]);
    d[1] = wrap9(s[11:8]);
    d[2] = wrap9(s[7:4]);
    for (int p = 0; p < 3; p++) begin
      if (d[0] == d[1]) begin
        d[0] = wrap9(d[0]);
      end
      if (d[0] == d[2]) begin
        d[0] = wrap9(d[0]);
      end
      if (d[1] == d[2]) begin
        d[1] = wrap9(d[1]);
      end
    end
    return d;
  endfunction

  always_ff @(posedge clk) begin
    if (!sharp_rst) begin
      lfsr         <= '0;
      load_q       <= 1'b0;
      o_secret     <= DEFAULT_SECRET;
      o_secret_stb <= 1'b0;
    end else begin
      load_q       <= i_seed_stb;
      o_secret_stb <= load_q;
      if (i_seed_stb) begin
        lfsr <= i_seed;
      end else if (load_q) begin
        lfsr     <= lfsr_next; // single shift per seed
        o_secret <= derive(lfsr_next);
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/key_entry.sv */
// keypad strobes are single cycle with no back-pressure; play-mode keys need i_key_en high
`timescale 1ns/1ps
`default_nettype none

module key_entry (
  input  wire                 clk,
  input  wire                 sharp_rst,
  input  wire [9:0]           i_numpad,
  input  wire                 i_star,
  input  wire                 i_seed_mode,
  input  wire                 i_key_en,
  input  wire                 i_clear,
  output game_pkg::guess_t    o_guess,
  output logic                o_submit,
  output game_pkg::seed_t     o_seed,
  output logic                o_seed_stb,
  output logic [3:0]          o_seed_fill
);
  import game_pkg::*;

  digit_t last_digit;
  digit_t key_digit;
  logic   key_hit;
  logic   keys_on;
  logic   dup;
  logic   digit_ok;

  always_comb begin
    key_digit = '0;
    for (int i = 0; i < 10; i++) begin
      if (i_numpad[i]) begin
        key_digit = digit_t'(i);
      end
    end
  end

  assign key_hit = |i_numpad;
  assign keys_on = i_seed_mode | i_key_en; // seeding stays open after a win or loss

  // distinct-digit rule against the filled slots only
  assign dup = ((o_guess.fill > 2'd0) && (last_digit == o_guess.d[0])) ||
               ((o_guess.fill > 2'd1) && (last_digit == o_guess.d[1]));
  assign digit_ok = (last_digit != 4'd0) && !dup;

  always_ff @(posedge clk) begin
    if (!sharp_rst) begin
      last_digit  <= '0;
      o_guess     <= '0;
      o_submit    <= 1'b0;
      o_seed      <= '0;
      o_seed_stb  <= 1'b0;
      o_seed_fill <= '0;
    end else begin
      o_submit   <= 1'b0;
      o_seed_stb <= 1'b0;
      if (key_hit && keys_on) begin
        last_digit <= key_digit;
      end
      if (i_seed_mode) begin
        if (i_star) begin
          o_seed      <= {o_seed[11:0], last_digit};
          o_seed_fill <= (o_seed_fill == 4'hf) ? 4'b0001 : {o_seed_fill[2:0], 1'b1};
          o_seed_stb  <= (o_seed_fill == 4'b0111); // fourth digit
        end
      end else if (i_key_en && i_star) begin
        if (o_guess.fill == 2'd3) begin
          o_submit <= 1'b1;
        end else if (digit_ok) begin
          o_guess.d[o_guess.fill] <= last_digit;
          o_guess.fill            <= o_guess.fill + 2'd1;
        end
      end
      if (i_clear) begin
        o_guess    <= '0;
        last_digit <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/display_pkg.sv */
// seven-segment encodings; segments active high in gfedcba order, position selects active low
`default_nettype none

package display_pkg;

  typedef logic [6:0] seg_t;     // gfedcba
  typedef logic [7:0] seg_pos_t; // one low bit selects a position

  parameter seg_t DIGIT_GLYPH [0:9] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66,
    7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f
  };

  parameter seg_t GLYPH_S = 7'h6d;
  parameter seg_t GLYPH_B = 7'h7c; // lower case b
  parameter seg_t BLANK   = 7'h00;

  parameter seg_pos_t POS_NONE = 8'hff;

  // codes above 9 show nothing
  function automatic seg_t digit_glyph(input logic [3:0] d);
    seg_t g;
    g = BLANK;
    if (d <= 4'd9) begin
      g = DIGIT_GLYPH[d];
    end
    return g;
  endfunction

endpackage

`default_nettype wire

/* verilog/game_pkg.sv */
// game types; guess and secret slot 0 is the leftmost digit, entered first
`default_nettype none

package game_pkg;

  typedef logic [3:0] digit_t; // decimal digit

  // guess as entered, fill counts stored slots
  typedef struct packed {
    digit_t [2:0] d;
    logic   [1:0] fill;
  } guess_t;

  typedef digit_t [2:0] secret_t;

  typedef logic [15:0] seed_t; // first seed digit in the top nibble

  typedef struct packed {
    logic [1:0] strikes;
    logic [1:0] balls;
  } score_t;

  typedef logic [3:0] try_cnt_t; // scored guesses so far

  typedef enum logic [1:0] {
    ENTRY,
    HOLD,
    WON,
    LOST
  } game_state_t;

endpackage

`default_nettype wire

/* include/baseball_config.svh */
// game constants; BB_HOLD_CYCLES is a short simulation value and must stay below 65536
`ifndef BASEBALL_CONFIG_SVH
`define BASEBALL_CONFIG_SVH

// scored guesses before the game is lost
`define BB_MAX_TRIES 10

// result hold time in clk cycles
`define BB_HOLD_CYCLES 64

// cycles each display position stays lit
`define BB_SCAN_DIV 4

// feedback taps 15, 13, 12, 10 of the 16-bit lfsr
`define BB_LFSR_TAPS 16'hB400

`endif
